/* cacheSys.f */
src/cachePkg.sv
src/busPkg.sv
src/lineSram.sv
src/refillUnit.sv
src/cacheCtrl.sv
src/cacheTop.sv
verification/cacheTop_properties.sv
verification/tbCacheTop.sv

/* src/busPkg.sv */
package busPkg;

  // load request from the pipeline
  typedef struct packed {
    logic [cachePkg::AddrBits-1:0] addr;
  } cpuReq_t;

  // load data back to the pipeline
  typedef struct packed {
    cachePkg::word_t data;
  } cpuRsp_t;

  // burst read towards memory
  // addr is line aligned, len is beats minus one
  typedef struct packed {
    logic [cachePkg::AddrBits-1:0] addr;
    logic [7:0]                    len;
  } memReq_t;

  // one data beat of a burst
  typedef struct packed {
    cachePkg::word_t data;
    logic            last;
  } memBeat_t;

endpackage

/* src/cacheCtrl.sv */
`timescale 1ns/100ps

module cacheCtrl #(
  parameter int IndexBits = 6
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      reqValid_i,
  input  busPkg::cpuReq_t           req_i,
  input  logic                      stall_n_i,
  output logic                      addrOk_o,
  output logic                      dataOk_o,
  output logic                      dataNotOk_o,
  output busPkg::cpuRsp_t           rsp_o,
  output logic                      refillStart_o,
  output cachePkg::lineAddr_t       refillAddr_o,
  input  logic                      refillDone_i,
  input  cachePkg::line_t           refillLine_i,
  output logic [1:0]                tagEn_o,
  output logic [1:0]                tagWe_o,
  output cachePkg::tagEntry_t [1:0] tagWdata_o,
  input  cachePkg::tagEntry_t [1:0] tagRdata_i,
  output logic [1:0]                dataEn_o,
  output logic [1:0]                dataWe_o,
  output cachePkg::line_t [1:0]     dataWdata_o,
  input  cachePkg::line_t [1:0]     dataRdata_i,
  output logic [IndexBits-1:0]      arrayIndex_o
);

  localparam int WordBits = $clog2(cachePkg::WordsPerLine);
  localparam int WordLsb = cachePkg::OffsetBits - WordBits;

  typedef enum logic [2:0] {SInit, SIdle, SCompare, SMiss, SRefill, SReplace} state_t;

  state_t                    stateQ;
  state_t                    stateD;
  busPkg::cpuReq_t           reqQ;
  logic [IndexBits-1:0]      initIdxQ;
  logic [(1<<IndexBits)-1:0] lruQ;
  logic                      victimQ;
  logic                      victim;
  logic                      accept;
  logic [1:0]                wayHit;
  logic                      hit;
  logic [IndexBits-1:0]      reqIdx;
  cachePkg::lineAddr_t       reqLine;
  logic [WordBits-1:0]       wordSel;
  cachePkg::line_t           hitLine;
  cachePkg::tagEntry_t       newEntry;

  // fields of the request under compare
  assign reqIdx = reqQ.addr[cachePkg::OffsetBits +: IndexBits];
  assign reqLine = reqQ.addr[cachePkg::AddrBits-1:cachePkg::OffsetBits];
  assign wordSel = reqQ.addr[WordLsb +: WordBits];

  // tag compare on the registered array outputs
  assign wayHit[0] = tagRdata_i[0].valid && (tagRdata_i[0].lineAddr == reqLine);
  assign wayHit[1] = tagRdata_i[1].valid && (tagRdata_i[1].lineAddr == reqLine);
  assign hit = |wayHit;

  // idle, or a hit in compare frees the pipe for the next load
  assign accept = reqValid_i && stall_n_i &&
                  (stateQ == SIdle || (stateQ == SCompare && hit));
  assign addrOk_o = accept;

  assign dataOk_o = (stateQ == SCompare && hit) || stateQ == SReplace;
  assign dataNotOk_o = (stateQ == SCompare && !hit) || stateQ == SMiss ||
                       stateQ == SRefill;

  // word select, refill buffer wins in replace
  assign hitLine = wayHit[1] ? dataRdata_i[1] : dataRdata_i[0];
  assign rsp_o.data = (stateQ == SReplace) ? refillLine_i[wordSel] : hitLine[wordSel];

  // free way first, else the lru way of the set
  assign victim = !tagRdata_i[0].valid ? 1'b0 :
                  !tagRdata_i[1].valid ? 1'b1 : lruQ[reqIdx];

  assign refillStart_o = (stateQ == SMiss);
  assign refillAddr_o = reqLine;

  always_comb begin
    stateD = stateQ;
    case (stateQ)
      SInit:    if (initIdxQ == '1) stateD = SIdle;
      SIdle:    if (accept) stateD = SCompare;
      SCompare: begin
        if (!hit) stateD = SMiss;
        else if (!accept) stateD = SIdle;
      end
      SMiss:    stateD = SRefill;
      SRefill:  if (refillDone_i) stateD = SReplace;
      SReplace: stateD = SIdle;
      default:  stateD = SInit;
    endcase
  end

  always_comb begin
    newEntry.valid = (stateQ != SInit);
    newEntry.lineAddr = (stateQ == SInit) ? '0 : reqLine;
    tagWdata_o[0] = newEntry;
    tagWdata_o[1] = newEntry;
    dataWdata_o[0] = refillLine_i;
    dataWdata_o[1] = refillLine_i;
    tagEn_o = '0;
    tagWe_o = '0;
    dataEn_o = '0;
    dataWe_o = '0;
    // read index comes straight from the incoming load
    arrayIndex_o = req_i.addr[cachePkg::OffsetBits +: IndexBits];
    case (stateQ)
      SInit: begin
        // clear one set of both tag arrays per cycle
        tagEn_o = '1;
        tagWe_o = '1;
        arrayIndex_o = initIdxQ;
      end
      SReplace: begin
        tagEn_o[victimQ] = 1'b1;
        tagWe_o[victimQ] = 1'b1;
        dataEn_o[victimQ] = 1'b1;
        dataWe_o[victimQ] = 1'b1;
        arrayIndex_o = reqIdx;
      end
      default: begin
        tagEn_o = {2{accept}};
        dataEn_o = {2{accept}};
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stateQ <= SInit;
      initIdxQ <= '0;
      lruQ <= '0;
      victimQ <= 1'b0;
    end else begin
      stateQ <= stateD;
      if (stateQ == SInit) initIdxQ <= initIdxQ + 1'b1;
      // lru bit names the way not touched last
      if (stateQ == SCompare && hit) lruQ[reqIdx] <= wayHit[0];
      if (stateQ == SReplace) lruQ[reqIdx] <= ~victimQ;
      // tag outputs still hold the missed set here
      if (stateQ == SMiss) victimQ <= victim;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) reqQ <= req_i;
  end

endmodule

/* src/cachePkg.sv */
package cachePkg;

  // 64-bit pipeline, 32-bit byte addresses
  localparam int XLen = 64;
  localparam int AddrBits = 32;

  // 256-bit lines, so 32 bytes per line
  localparam int OffsetBits = 5;
  localparam int WordsPerLine = 4;

  // one pipeline word
  typedef logic [XLen-1:0] word_t;

  // a full cache line
  // word 0 sits in the low bits, matching beat order from memory
  typedef word_t [WordsPerLine-1:0] line_t;

  // address bits above the byte offset
  typedef logic [AddrBits-OffsetBits-1:0] lineAddr_t;

  // tag entry keeps the whole line address
  // so the format stays the same for any number of sets
  typedef struct packed {
    logic      valid;
    lineAddr_t lineAddr;
  } tagEntry_t;

endpackage

/* src/cacheTop.sv */
`timescale 1ns/100ps

module cacheTop #(
  parameter int IndexBits = 6
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              reqValid_i,
  input  busPkg::cpuReq_t   req_i,
  input  logic              stall_n_i,
  output logic              addrOk_o,
  output logic              dataOk_o,
  output logic              dataNotOk_o,
  output busPkg::cpuRsp_t   rsp_o,
  output logic              memReqValid_o,
  output busPkg::memReq_t   memReq_o,
  input  logic              memReady_i,
  input  logic              beatValid_i,
  input  busPkg::memBeat_t  beat_i
);

  // controller to refill unit
  logic                      refillStart;
  cachePkg::lineAddr_t       refillAddr;
  logic                      refillDone;
  cachePkg::line_t           refillLine;

  // per way array control
  logic [1:0]                tagEn;
  logic [1:0]                tagWe;
  cachePkg::tagEntry_t [1:0] tagWdata;
  cachePkg::tagEntry_t [1:0] tagRdata;
  logic [1:0]                dataEn;
  logic [1:0]                dataWe;
  cachePkg::line_t [1:0]     dataWdata;
  cachePkg::line_t [1:0]     dataRdata;
  logic [IndexBits-1:0]      arrayIndex;

  cacheCtrl #(.IndexBits(IndexBits)) uCtrl (
    .clk, .rst_n,
    .reqValid_i, .req_i, .stall_n_i,
    .addrOk_o, .dataOk_o, .dataNotOk_o, .rsp_o,
    .refillStart_o(refillStart), .refillAddr_o(refillAddr),
    .refillDone_i(refillDone), .refillLine_i(refillLine),
    .tagEn_o(tagEn), .tagWe_o(tagWe), .tagWdata_o(tagWdata), .tagRdata_i(tagRdata),
    .dataEn_o(dataEn), .dataWe_o(dataWe), .dataWdata_o(dataWdata), .dataRdata_i(dataRdata),
    .arrayIndex_o(arrayIndex)
  );

  refillUnit uRefill (
    .clk, .rst_n,
    .start_i(refillStart), .lineAddr_i(refillAddr),
    .memReqValid_o, .memReq_o, .memReady_i,
    .beatValid_i, .beat_i,
    .done_o(refillDone), .line_o(refillLine)
  );

  // tag and data array for each of the two ways
  for (genvar w = 0; w < 2; w++) begin : gWay
    lineSram #(.Depth(1 << IndexBits), .payload_t(cachePkg::tagEntry_t)) uTagSram (
      .clk, .en_i(tagEn[w]), .we_i(tagWe[w]), .addr_i(arrayIndex),
      .wdata_i(tagWdata[w]), .rdata_o(tagRdata[w])
    );
    lineSram #(.Depth(1 << IndexBits), .payload_t(cachePkg::line_t)) uDataSram (
      .clk, .en_i(dataEn[w]), .we_i(dataWe[w]), .addr_i(arrayIndex),
      .wdata_i(dataWdata[w]), .rdata_o(dataRdata[w])
    );
  end

endmodule

/* src/lineSram.sv */
`timescale 1ns/100ps

module lineSram #(
  parameter int Depth = 64,
  parameter type payload_t = logic [31:0]
) (
  input  logic                     clk,
  input  logic                     en_i,
  input  logic                     we_i,
  input  logic [$clog2(Depth)-1:0] addr_i,
  input  payload_t                 wdata_i,
  output payload_t                 rdata_o
);

  // storage array, one payload per set
  payload_t mem [Depth];

  // single port, read data registered
  // a write also shows up on the read port next cycle
  always_ff @(posedge clk) begin
    if (en_i) begin
      if (we_i) begin
        mem[addr_i] <= wdata_i;
        rdata_o <= wdata_i;
      end else begin
        // plain read
        rdata_o <= mem[addr_i];
      end
    end
  end

endmodule

/* src/refillUnit.sv */
`timescale 1ns/100ps

module refillUnit (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                start_i,
  input  cachePkg::lineAddr_t lineAddr_i,
  output logic                memReqValid_o,
  output busPkg::memReq_t     memReq_o,
  input  logic                memReady_i,
  input  logic                beatValid_i,
  input  busPkg::memBeat_t    beat_i,
  output logic                done_o,
  output cachePkg::line_t     line_o
);

  typedef enum logic [1:0] {RIdle, RReq, RBeats} rState_t;

  rState_t                                   stateQ;
  rState_t                                   stateD;
  cachePkg::lineAddr_t                       addrQ;
  logic [$clog2(cachePkg::WordsPerLine)-1:0] beatCntQ;
  cachePkg::line_t                           lineQ;
  logic                                      beatTake;

  // request goes out in the start cycle, then held until ready
  assign memReqValid_o = (stateQ == RIdle && start_i) || stateQ == RReq;
  assign beatTake = (stateQ == RBeats) && beatValid_i;
  // last beat ends the burst
  assign done_o = beatTake && beat_i.last;
  assign line_o = lineQ;

  always_comb begin
    memReq_o.addr = {(stateQ == RIdle) ? lineAddr_i : addrQ, {cachePkg::OffsetBits{1'b0}}};
    // always a full line
    memReq_o.len = 8'(cachePkg::WordsPerLine - 1);
  end

  always_comb begin
    stateD = stateQ;
    case (stateQ)
      RIdle:  if (start_i) stateD = memReady_i ? RBeats : RReq;
      RReq:   if (memReady_i) stateD = RBeats;
      RBeats: if (done_o) stateD = RIdle;
      default: stateD = RIdle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stateQ <= RIdle;
      beatCntQ <= '0;
    end else begin
      stateQ <= stateD;
      // word slot for the next beat
      if (start_i && stateQ == RIdle) beatCntQ <= '0;
      else if (beatTake) beatCntQ <= beatCntQ + 1'b1;
    end
  end

  // line buffer stays put until the next start, for the replay
  always_ff @(posedge clk) begin
    if (start_i && stateQ == RIdle) addrQ <= lineAddr_i;
    if (beatTake) lineQ[beatCntQ] <= beat_i.data;
  end

endmodule

/* verification/cacheTop_properties.sv */
`timescale 1ns/100ps

module cacheTop_properties (
  input logic            clk,
  input logic            rst_n,
  input logic            memReqValid_o,
  input busPkg::memReq_t memReq_o,
  input logic            memReady_i,
  input logic            addrOk_o,
  input logic            dataOk_o,
  input logic            dataNotOk_o
);

  // failed assertions so far
  int failCount = 0;

  // burst request stays up and unchanged until memory takes it
  property memReqHeld;
    @(posedge clk) disable iff (!rst_n)
      memReqValid_o && !memReady_i |=> memReqValid_o && $stable(memReq_o);
  endproperty

  // hit data and miss indication are exclusive
  property okFlagsExclusive;
    @(posedge clk) disable iff (!rst_n)
      !(dataOk_o && dataNotOk_o);
  endproperty

  // an accepted load shows hit data or the miss flag in the next cycle
  property acceptAnswered;
    @(posedge clk) disable iff (!rst_n)
      addrOk_o |=> dataOk_o || dataNotOk_o;
  endproperty

  assert property (memReqHeld) else begin
    failCount++;
    $error("memory request changed before ready");
  end
  assert property (okFlagsExclusive) else begin
    failCount++;
    $error("dataOk_o and dataNotOk_o high together");
  end
  assert property (acceptAnswered) else begin
    failCount++;
    $error("accepted load got neither dataOk_o nor dataNotOk_o");
  end

endmodule

bind cacheTop cacheTop_properties uProps (
  .clk(clk),
  .rst_n(rst_n),
  .memReqValid_o(memReqValid_o),
  .memReq_o(memReq_o),
  .memReady_i(memReady_i),
  .addrOk_o(addrOk_o),
  .dataOk_o(dataOk_o),
  .dataNotOk_o(dataNotOk_o)
);

/* verification/tbCacheTop.sv */
`timescale 1ns/100ps

module tbCacheTop;

  localparam int IndexBits = 6;
  localparam int Sets = 1 << IndexBits;
  // worst miss is accept, compare, miss, ready wait 3, four beats with gaps, replace
  localparam int MissCycles = 24;
  localparam int NumLoads = 25;
  localparam int InitCycles = Sets + 10;
  localparam int StallCycles = 10;
  localparam int CycleLimit = 2 * (InitCycles + NumLoads * MissCycles + StallCycles);

  logic             clk;
  logic             rst_n;
  logic             reqValid_i;
  busPkg::cpuReq_t  req_i;
  logic             stall_n_i;
  logic             addrOk_o;
  logic             dataOk_o;
  logic             dataNotOk_o;
  busPkg::cpuRsp_t  rsp_o;
  logic             memReqValid_o;
  busPkg::memReq_t  memReq_o;
  logic             memReady_i;
  logic             beatValid_i;
  busPkg::memBeat_t beat_i;

  // memory side bookkeeping
  integer      seed = 32'hc3a45d5e;
  int          memReqCount;
  logic [31:0] lastReqAddr;
  logic [7:0]  lastReqLen;
  bit          slowMem;
  int          cycleCount;

  // two-way lru model with one bit per set naming the next victim
  cachePkg::lineAddr_t modelTag [Sets][2];
  logic                modelValid [Sets][2];
  logic                modelLru [Sets];

  cacheTop #(.IndexBits(IndexBits)) DUT (
    .clk, .rst_n,
    .reqValid_i, .req_i, .stall_n_i,
    .addrOk_o, .dataOk_o, .dataNotOk_o, .rsp_o,
    .memReqValid_o, .memReq_o, .memReady_i,
    .beatValid_i, .beat_i
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic stopOnError(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic compareValue(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
    if (actual !== expected) begin
      stopOnError($sformatf("FAIL at %0t: %s = %h, expected %h", $time, name, actual,
                            expected));
    end
  endtask

  // upper half the word's byte address, lower half its inverse
  function automatic cachePkg::word_t expectedWord(input logic [31:0] addr);
    logic [31:0] wordAddr;
    wordAddr = {addr[31:3], 3'b000};
    return {wordAddr, ~wordAddr};
  endfunction

  // returns 1 on a predicted hit and updates tags and lru
  function automatic logic modelAccess(input logic [31:0] addr);
    int                  set;
    int                  w;
    logic                hit;
    logic                way;
    cachePkg::lineAddr_t line;
    line = addr[31:cachePkg::OffsetBits];
    set = int'(addr[cachePkg::OffsetBits +: IndexBits]);
    hit = 1'b0;
    way = 1'b0;
    for (w = 0; w < 2; w++) begin
      if (modelValid[set][w] && modelTag[set][w] == line) begin
        hit = 1'b1;
        way = w[0];
      end
    end
    if (!hit) begin
      // empty way first, then lru
      if (!modelValid[set][0]) way = 1'b0;
      else if (!modelValid[set][1]) way = 1'b1;
      else way = modelLru[set];
      modelValid[set][way] = 1'b1;
      modelTag[set][way] = line;
    end
    modelLru[set] = ~way;
    return hit;
  endfunction

  // memory responder with random ready delay and beat gaps
  initial begin
    int          readyDelay;
    int          gap;
    int          b;
    logic [31:0] base;
    memReady_i = 1'b0;
    beatValid_i = 1'b0;
    beat_i = '0;
    forever begin
      @(negedge clk);
      if (memReqValid_o) begin
        readyDelay = slowMem ? 3 : $unsigned($random(seed)) % 4;
        repeat (readyDelay) @(negedge clk);
        memReady_i = 1'b1;
        @(posedge clk);
        memReqCount++;
        lastReqAddr = memReq_o.addr;
        lastReqLen = memReq_o.len;
        base = memReq_o.addr;
        @(negedge clk);
        memReady_i = 1'b0;
        for (b = 0; b < cachePkg::WordsPerLine; b++) begin
          gap = slowMem ? 2 : $unsigned($random(seed)) % 3;
          repeat (gap) @(negedge clk);
          beatValid_i = 1'b1;
          beat_i.data = expectedWord(base + 32'(b * 8));
          beat_i.last = (b == cachePkg::WordsPerLine - 1);
          @(negedge clk);
          beatValid_i = 1'b0;
        end
      end
    end
  end

  // watchdog
  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= CycleLimit) stopOnError("timeout: the run exceeded its cycle limit");
  end

  // a handshake assertion in the bound checker fired
  always @(DUT.uProps.failCount) begin
    if (DUT.uProps.failCount != 0) stopOnError("a handshake assertion on cacheTop failed");
  end

  // one load checked against the model's hit or miss
  task automatic loadCheck(input logic [31:0] addr);
    logic expHit;
    int   reqsBefore;
    expHit = modelAccess(addr);
    reqsBefore = memReqCount;
    @(negedge clk);
    reqValid_i = 1'b1;
    req_i.addr = addr;
    @(posedge clk);
    while (!addrOk_o) @(posedge clk);
    @(negedge clk);
    reqValid_i = 1'b0;
    @(posedge clk);
    if (expHit) begin
      compareValue("dataOk_o", dataOk_o, 1);
      compareValue("memReqValid_o", memReqValid_o, 0);
    end else begin
      compareValue("dataNotOk_o", dataNotOk_o, 1);
      // burst request goes out the cycle after the miss shows
      @(posedge clk);
      compareValue("memReqValid_o", memReqValid_o, 1);
      while (!dataOk_o) @(posedge clk);
      compareValue("memReq_o.addr", lastReqAddr, {addr[31:5], 5'b0});
      compareValue("memReq_o.len", lastReqLen, 3);
    end
    compareValue("rsp_o", rsp_o.data, expectedWord(addr));
    compareValue("memory requests", 64'(memReqCount - reqsBefore), expHit ? 0 : 1);
  endtask

  task automatic coldMissThenHit();
    loadCheck(32'h0000_1048);
    loadCheck(32'h0000_1048);
  endtask

  task automatic wordSelect();
    int reqsBefore;
    reqsBefore = memReqCount;
    loadCheck(32'h0004_2110);
    loadCheck(32'h0004_2100);
    loadCheck(32'h0004_2118);
    loadCheck(32'h0004_2108);
    compareValue("memory requests", 64'(memReqCount - reqsBefore), 1);
  endtask

  // lines a, b, c all land in set 5
  task automatic lruReplace();
    int reqsBefore;
    reqsBefore = memReqCount;
    loadCheck(32'h0001_00A0);
    loadCheck(32'h0001_08A8);
    loadCheck(32'h0001_00B0);
    loadCheck(32'h0001_10A0);
    loadCheck(32'h0001_00B8);
    // b was least recent, so it comes back from memory
    loadCheck(32'h0001_08B0);
    compareValue("memory requests", 64'(memReqCount - reqsBefore), 4);
  endtask

  task automatic backToBackHits();
    logic [31:0]     addrs [5];
    cachePkg::word_t expQ [$];
    int              issued;
    int              returned;
    int              cycle;
    int              firstAccept;
    int              lastReturn;
    int              reqsBefore;
    int              i;
    addrs = '{32'h0004_2108, 32'h0001_00A0, 32'h0004_2118, 32'h0001_08B0, 32'h0004_2100};
    issued = 0;
    returned = 0;
    cycle = 0;
    firstAccept = -1;
    lastReturn = 0;
    reqsBefore = memReqCount;
    for (i = 0; i < 5; i++) compareValue("model hit", modelAccess(addrs[i]), 1);
    @(negedge clk);
    reqValid_i = 1'b1;
    req_i.addr = addrs[0];
    while (returned < 5) begin
      @(posedge clk);
      cycle++;
      if (dataOk_o) begin
        if (expQ.size() == 0) stopOnError("response with no load in flight");
        compareValue("rsp_o", rsp_o.data, expQ.pop_front());
        returned++;
        lastReturn = cycle;
      end
      if (addrOk_o && issued < 5) begin
        expQ.push_back(expectedWord(addrs[issued]));
        if (firstAccept < 0) firstAccept = cycle;
        issued++;
      end
      @(negedge clk);
      if (issued < 5) req_i.addr = addrs[issued];
      else reqValid_i = 1'b0;
    end
    // five answers in the five cycles after the first accept
    compareValue("back-to-back cycles", 64'(lastReturn - firstAccept), 5);
    compareValue("memory requests", 64'(memReqCount - reqsBefore), 0);
  endtask

  task automatic backPressure();
    logic [31:0] addrA;
    addrA = 32'h0001_00A8;
    // stalled pipe accepts nothing
    @(negedge clk);
    stall_n_i = 1'b0;
    reqValid_i = 1'b1;
    req_i.addr = addrA;
    repeat (4) begin
      @(posedge clk);
      compareValue("addrOk_o", addrOk_o, 0);
    end
    @(negedge clk);
    stall_n_i = 1'b1;
    @(posedge clk);
    while (!addrOk_o) @(posedge clk);
    compareValue("model hit", modelAccess(addrA), 1);
    // hit in flight finishes under stall
    @(negedge clk);
    reqValid_i = 1'b0;
    stall_n_i = 1'b0;
    @(posedge clk);
    compareValue("dataOk_o", dataOk_o, 1);
    compareValue("rsp_o", rsp_o.data, expectedWord(addrA));
    @(negedge clk);
    stall_n_i = 1'b1;
    // late ready, wide beat gaps
    slowMem = 1'b1;
    loadCheck(32'h0008_3FF8);
    loadCheck(32'h0010_0010);
    loadCheck(32'h0010_0018);
    slowMem = 1'b0;
  endtask

  initial begin
    int s;
    rst_n = 1'b0;
    reqValid_i = 1'b0;
    req_i = '0;
    stall_n_i = 1'b1;
    memReqCount = 0;
    lastReqAddr = '0;
    lastReqLen = '0;
    slowMem = 1'b0;
    cycleCount = 0;
    for (s = 0; s < Sets; s++) begin
      modelValid[s][0] = 1'b0;
      modelValid[s][1] = 1'b0;
      modelTag[s][0] = '0;
      modelTag[s][1] = '0;
      modelLru[s] = 1'b0;
    end
    repeat (5) @(posedge clk);
    // quiet handshakes while in reset
    compareValue("addrOk_o", addrOk_o, 0);
    compareValue("dataOk_o", dataOk_o, 0);
    compareValue("dataNotOk_o", dataNotOk_o, 0);
    compareValue("memReqValid_o", memReqValid_o, 0);
    @(negedge clk);
    rst_n = 1'b1;
    coldMissThenHit();
    wordSelect();
    lruReplace();
    backToBackHits();
    backPressure();
    repeat (2) @(negedge clk);
    $display("Simulation PASSED");
    $finish;
  end

endmodule
